//--- common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_XORI  6'h0e
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// r-type function codes, instr[5:0]
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_SLT 6'h2a

// storage sizes
`define DMEM_WORDS 64
`define NUM_REGS   32

`endif

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [15:0] imm16_t;
	typedef logic [25:0] jidx_t;

	// eq and ne only feed branch resolution
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_lui,
		alu_eq,
		alu_ne
	} alu_op_t;

	typedef struct packed {
		logic    regwrite;
		logic    memtoreg;
		logic    memread;
		logic    memwrite;
		logic    isbranch;
		logic    isjump;
		logic    regdst;
		logic    alusrc;
		alu_op_t aluop;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		ctrl_t    ctrl;
		word_t    pc;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dest;
		word_t    rs_val;
		word_t    rt_val;
		word_t    imm;
		jidx_t    jidx;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		logic     regwrite;
		logic     memtoreg;
		logic     memread;
		logic     memwrite;
		reg_idx_t dest;
		// alu value, or the byte address for loads and stores
		word_t    result;
		word_t    store_data;
	} ex_mem_t;

	typedef struct packed {
		logic     en;
		reg_idx_t dest;
		word_t    data;
	} wb_t;

endpackage

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     stall,
	input  wire                     redirect,
	input  wire  mips_pkg::word_t   redirect_pc,
	output mips_pkg::word_t         imem_addr,
	input  wire  mips_pkg::word_t   imem_data,
	output mips_pkg::if_id_t        if_id
);

	import mips_pkg::*;

	word_t pc;
	word_t pc_next;

	// byte address straight from the pc
	assign imem_addr = pc;

	assign pc_next = pc + 32'd4;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc    <= '0;
			if_id <= '0;
		end else if (redirect) begin
			// redirect wins over a stall, the word fetched this cycle is dropped
			pc          <= redirect_pc;
			if_id.valid <= 1'b0;
		end else if (!stall) begin
			pc          <= pc_next;
			if_id.valid <= 1'b1;
			if_id.pc    <= pc;
			if_id.instr <= imem_data;
		end
	end

endmodule

`default_nettype wire

//--- decode/control.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module control (
	input  wire  mips_pkg::opcode_t opcode,
	input  wire  mips_pkg::funct_t  funct,
	output mips_pkg::ctrl_t         ctrl
);

	import mips_pkg::*;

	always_comb begin
		// everything off is a bubble
		ctrl       = '0;
		ctrl.aluop = alu_add;
		case (opcode)
			`OP_RTYPE: begin
				ctrl.regdst = 1'b1;
				ctrl.regwrite = 1'b1;
				case (funct)
					`FN_ADD: ctrl.aluop = alu_add;
					`FN_SUB: ctrl.aluop = alu_sub;
					`FN_AND: ctrl.aluop = alu_and;
					`FN_OR:  ctrl.aluop = alu_or;
					`FN_XOR: ctrl.aluop = alu_xor;
					`FN_SLT: ctrl.aluop = alu_slt;
					// unlisted funct, so sll $0,$0,0 lands here as a no-op
					default: begin
						ctrl.regdst   = 1'b0;
						ctrl.regwrite = 1'b0;
					end
				endcase
			end
			`OP_ADDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			`OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			`OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			`OP_J: ctrl.isjump = 1'b1;
			`OP_ANDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = alu_and;
			end
			`OP_ORI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = alu_or;
			end
			`OP_XORI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = alu_xor;
			end
			`OP_SLTI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = alu_slt;
			end
			`OP_BEQ: begin
				ctrl.isbranch = 1'b1;
				ctrl.aluop    = alu_eq;
			end
			`OP_BNE: begin
				ctrl.isbranch = 1'b1;
				ctrl.aluop    = alu_ne;
			end
			`OP_LUI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = alu_lui;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module reg_file (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire  mips_pkg::reg_idx_t rs,
	input  wire  mips_pkg::reg_idx_t rt,
	output mips_pkg::word_t         rs_val,
	output mips_pkg::word_t         rt_val,
	input  wire  mips_pkg::wb_t     wb
);

	import mips_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en && wb.dest != '0) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// write-through so decode sees this cycle's writeback
	always_comb begin
		if (rs == '0)                      rs_val = '0;
		else if (wb.en && wb.dest == rs)   rs_val = wb.data;
		else                               rs_val = regs[rs];
		if (rt == '0)                      rt_val = '0;
		else if (wb.en && wb.dest == rt)   rt_val = wb.data;
		else                               rt_val = regs[rt];
	end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire  mips_pkg::if_id_t if_id,
	input  wire                    redirect,
	input  wire  mips_pkg::wb_t    wb,
	output logic                   stall,
	output mips_pkg::id_ex_t       id_ex
);

	import mips_pkg::*;

	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	imm16_t   imm16;
	ctrl_t    ctrl;
	word_t    rs_val;
	word_t    rt_val;
	logic     zext;
	id_ex_t   id_ex_d;

	assign rs    = if_id.instr[25:21];
	assign rt    = if_id.instr[20:16];
	assign rd    = if_id.instr[15:11];
	assign imm16 = if_id.instr[15:0];

	control u_control (
		.opcode (if_id.instr[31:26]),
		.funct  (if_id.instr[5:0]),
		.ctrl   (ctrl)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.rs     (rs),
		.rt     (rt),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.wb     (wb)
	);

	// logical immediates are zero-extended
	assign zext = ctrl.alusrc && (ctrl.aluop inside {alu_and, alu_or, alu_xor});

	// load in execute feeding the instruction in decode
	assign stall = if_id.valid && id_ex.valid && id_ex.ctrl.memread &&
		id_ex.dest != '0 && (id_ex.dest == rs || id_ex.dest == rt);

	always_comb begin
		id_ex_d.valid  = if_id.valid && !stall && !redirect;
		id_ex_d.ctrl   = ctrl;
		id_ex_d.pc     = if_id.pc;
		id_ex_d.rs     = rs;
		id_ex_d.rt     = rt;
		id_ex_d.dest   = ctrl.regdst ? rd : rt;
		id_ex_d.rs_val = rs_val;
		id_ex_d.rt_val = rt_val;
		id_ex_d.imm    = zext ? {16'h0, imm16} : {{16{imm16[15]}}, imm16};
		id_ex_d.jidx   = if_id.instr[25:0];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) id_ex <= '0;
		else         id_ex <= id_ex_d;
	end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire  mips_pkg::id_ex_t id_ex,
	input  wire  mips_pkg::wb_t    wb,
	output logic                   redirect,
	output mips_pkg::word_t        redirect_pc,
	output mips_pkg::ex_mem_t      ex_mem
);

	import mips_pkg::*;

	word_t op_a;
	word_t rt_fwd;
	word_t op_b;
	word_t alu_y;
	word_t pc_plus4;
	logic  taken;

	// ex_mem is the younger producer and wins over wb
	function automatic word_t fwd(input reg_idx_t idx, input word_t val,
		input ex_mem_t em, input wb_t w);
		word_t r;
		r = val;
		if (idx != '0) begin
			if (em.valid && em.regwrite && !em.memread && em.dest == idx)
				r = em.result;
			else if (w.en && w.dest == idx)
				r = w.data;
		end
		return r;
	endfunction

	assign op_a   = fwd(id_ex.rs, id_ex.rs_val, ex_mem, wb);
	assign rt_fwd = fwd(id_ex.rt, id_ex.rt_val, ex_mem, wb);
	assign op_b   = id_ex.ctrl.alusrc ? id_ex.imm : rt_fwd;

	always_comb begin
		case (id_ex.ctrl.aluop)
			alu_add: alu_y = op_a + op_b;
			alu_sub: alu_y = op_a - op_b;
			alu_and: alu_y = op_a & op_b;
			alu_or:  alu_y = op_a | op_b;
			alu_xor: alu_y = op_a ^ op_b;
			alu_slt: alu_y = {31'h0, $signed(op_a) < $signed(op_b)};
			alu_lui: alu_y = {op_b[15:0], 16'h0};
			alu_eq:  alu_y = {31'h0, op_a == op_b};
			alu_ne:  alu_y = {31'h0, op_a != op_b};
			default: alu_y = op_a + op_b;
		endcase
	end

	assign pc_plus4 = id_ex.pc + 32'd4;

	// branch condition comes out of the alu in bit 0
	assign taken = id_ex.valid &&
		(id_ex.ctrl.isjump || (id_ex.ctrl.isbranch && alu_y[0]));

	assign redirect    = taken;
	assign redirect_pc = id_ex.ctrl.isjump ? {pc_plus4[31:28], id_ex.jidx, 2'b00}
	                                       : pc_plus4 + {id_ex.imm[29:0], 2'b00};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.regwrite   <= id_ex.ctrl.regwrite;
			ex_mem.memtoreg   <= id_ex.ctrl.memtoreg;
			ex_mem.memread    <= id_ex.ctrl.memread;
			ex_mem.memwrite   <= id_ex.ctrl.memwrite;
			ex_mem.dest       <= id_ex.dest;
			ex_mem.result     <= alu_y;
			ex_mem.store_data <= rt_fwd;
		end
	end

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mem_stage (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire  mips_pkg::ex_mem_t ex_mem,
	output mips_pkg::wb_t           wb
);

	import mips_pkg::*;

	localparam int AW = $clog2(`DMEM_WORDS);

	word_t          dmem [`DMEM_WORDS];
	logic [AW-1:0]  idx;
	word_t          load_data;
	word_t          wb_data_d;

	// word index, byte offset ignored
	assign idx = ex_mem.result[AW+1:2];

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.memwrite) dmem[idx] <= ex_mem.store_data;
	end

	assign load_data = dmem[idx];
	assign wb_data_d = ex_mem.memtoreg ? load_data : ex_mem.result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
		end else begin
			// writes to $0 never show up on the port
			wb.en   <= ex_mem.valid && ex_mem.regwrite && ex_mem.dest != '0;
			wb.dest <= ex_mem.dest;
			wb.data <= wb_data_d;
		end
	end

endmodule

`default_nettype wire

//--- src/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  wire                      clk,
	input  wire                      arst_n,
	output mips_pkg::word_t          imem_addr,
	input  wire  mips_pkg::word_t    imem_data,
	output logic                     wb_en,
	output mips_pkg::reg_idx_t       wb_reg,
	output mips_pkg::word_t          wb_data
);

	import mips_pkg::*;

	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	wb_t     wb;
	logic    stall;
	logic    redirect;
	word_t   redirect_pc;

	fetch_stage u_fetch (
		.clk         (clk),
		.arst_n      (arst_n),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.if_id       (if_id)
	);

	decode_stage u_decode (
		.clk      (clk),
		.arst_n   (arst_n),
		.if_id    (if_id),
		.redirect (redirect),
		.wb       (wb),
		.stall    (stall),
		.id_ex    (id_ex)
	);

	execute_stage u_execute (
		.clk         (clk),
		.arst_n      (arst_n),
		.id_ex       (id_ex),
		.wb          (wb),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ex_mem      (ex_mem)
	);

	mem_stage u_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.ex_mem (ex_mem),
		.wb     (wb)
	);

	// writeback port mirrors what the register file receives
	assign wb_en   = wb.en;
	assign wb_reg  = wb.dest;
	assign wb_data = wb.data;

endmodule

`default_nettype wire

//--- testbench/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_core_tb;

	import mips_pkg::*;

	localparam int PROG_LEN    = 33;
	localparam int EXP_LEN     = 23;
	localparam int NUM_TESTS   = 6;
	localparam int CYCLE_LIMIT = 4 * PROG_LEN + 20;

	logic        clk;
	logic        arst_n;
	word_t       imem_addr;
	word_t       imem_data;
	logic        wb_en;
	reg_idx_t    wb_reg;
	word_t       wb_data;
	logic [29:0] imem_word;

	word_t       prog [PROG_LEN];
	reg_idx_t    exp_reg [EXP_LEN];
	word_t       exp_val [EXP_LEN];
	int          exp_test [EXP_LEN];
	int          test_err [1:NUM_TESTS];
	bit          test_done [1:NUM_TESTS];
	int          n_prog;
	int          n_exp;
	int          consumed;
	int          errors;
	int          checks;
	int          cycles;
	int          passed;

	mips_core i_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb_en     (wb_en),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

	// word-indexed instruction memory that reads zero (a no-op) past the table
	assign imem_word = imem_addr[31:2];
	assign imem_data = (imem_word < PROG_LEN) ? prog[imem_word] : 32'h0;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic word_t rtype_word(funct_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t itype_word(opcode_t op, reg_idx_t rt, reg_idx_t rs, imm16_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(jidx_t idx);
		return {`OP_J, idx};
	endfunction

	function automatic string test_name(int t);
		case (t)
			1:       return "reset";
			2:       return "alu and forwarding";
			3:       return "immediates";
			4:       return "memory and register 0";
			5:       return "branches";
			6:       return "jump";
			default: return "unknown";
		endcase
	endfunction

	task automatic put_instr(word_t w);
		prog[n_prog] = w;
		n_prog++;
	endtask

	task automatic expect_write(int test, reg_idx_t r, word_t v);
		exp_test[n_exp] = test;
		exp_reg[n_exp]  = r;
		exp_val[n_exp]  = v;
		n_exp++;
	endtask

	task automatic load_program();
		// dependent alu chain with operands from both later stages
		put_instr(itype_word(`OP_ORI, 1, 0, 16'h00f0));
		put_instr(itype_word(`OP_ADDI, 2, 1, 16'h0010));
		put_instr(rtype_word(`FN_ADD, 3, 1, 2));
		put_instr(rtype_word(`FN_SUB, 4, 3, 1));
		put_instr(rtype_word(`FN_AND, 5, 4, 3));
		put_instr(rtype_word(`FN_OR, 6, 5, 1));
		put_instr(rtype_word(`FN_XOR, 7, 6, 4));
		put_instr(rtype_word(`FN_SLT, 8, 7, 6));
		put_instr(rtype_word(`FN_SUB, 9, 1, 3));
		put_instr(rtype_word(`FN_SLT, 10, 9, 1));
		// lui, negative slti, logical ops with bit 15 set
		put_instr(itype_word(`OP_LUI, 11, 0, 16'h1234));
		put_instr(itype_word(`OP_SLTI, 12, 9, 16'hffff));
		put_instr(itype_word(`OP_SLTI, 13, 0, 16'hffff));
		put_instr(itype_word(`OP_ORI, 14, 11, 16'h8001));
		put_instr(itype_word(`OP_ANDI, 15, 9, 16'h8f0f));
		put_instr(itype_word(`OP_XORI, 16, 9, 16'h8000));
		// store then load, load-use, writes aimed at $0
		put_instr(itype_word(`OP_SW, 14, 0, 16'h0008));
		put_instr(itype_word(`OP_LW, 17, 0, 16'h0008));
		put_instr(rtype_word(`FN_ADD, 18, 17, 1));
		put_instr(itype_word(`OP_ADDI, 0, 1, 16'h0005));
		put_instr(itype_word(`OP_LW, 0, 0, 16'h0008));
		put_instr(rtype_word(`FN_ADD, 19, 0, 1));
		// beq taken over two tagged writes, bne not taken
		put_instr(itype_word(`OP_BEQ, 2, 5, 16'h0002));
		put_instr(itype_word(`OP_ADDI, 20, 0, 16'h0bad));
		put_instr(itype_word(`OP_ADDI, 21, 0, 16'h0bad));
		put_instr(itype_word(`OP_BNE, 4, 2, 16'h0002));
		put_instr(itype_word(`OP_ADDI, 22, 0, 16'h0055));
		put_instr(itype_word(`OP_ADDI, 23, 22, 16'h0001));
		// jump to word 31 over two tagged writes
		put_instr(jump_word(26'd31));
		put_instr(itype_word(`OP_ADDI, 24, 0, 16'h0bad));
		put_instr(itype_word(`OP_ADDI, 25, 0, 16'h0bad));
		put_instr(itype_word(`OP_ADDI, 26, 0, 16'h0077));
		put_instr(rtype_word(`FN_XOR, 27, 26, 11));
	endtask

	task automatic load_expected();
		expect_write(2, 1, 32'h0000_00f0);
		expect_write(2, 2, 32'h0000_0100);
		expect_write(2, 3, 32'h0000_01f0);
		expect_write(2, 4, 32'h0000_0100);
		expect_write(2, 5, 32'h0000_0100);
		expect_write(2, 6, 32'h0000_01f0);
		expect_write(2, 7, 32'h0000_00f0);
		expect_write(2, 8, 32'h0000_0001);
		expect_write(2, 9, 32'hffff_ff00);
		expect_write(2, 10, 32'h0000_0001);
		expect_write(3, 11, 32'h1234_0000);
		expect_write(3, 12, 32'h0000_0001);
		expect_write(3, 13, 32'h0000_0000);
		expect_write(3, 14, 32'h1234_8001);
		expect_write(3, 15, 32'h0000_8f00);
		expect_write(3, 16, 32'hffff_7f00);
		expect_write(4, 17, 32'h1234_8001);
		expect_write(4, 18, 32'h1234_80f1);
		expect_write(4, 19, 32'h0000_00f0);
		expect_write(5, 22, 32'h0000_0055);
		expect_write(5, 23, 32'h0000_0056);
		expect_write(6, 26, 32'h0000_0077);
		expect_write(6, 27, 32'h1234_0077);
	endtask

	task automatic report_test(int t);
		test_done[t] = 1'b1;
		if (test_err[t] == 0) begin
			passed++;
			$display("test %0d %s: pass", t, test_name(t));
		end else begin
			$display("test %0d %s: FAIL, %0d errors", t, test_name(t), test_err[t]);
		end
	endtask

	task automatic check_reset_outputs();
		checks++;
		if (wb_en !== 1'b0) begin
			$display("ERROR t=%0t wb_en: got %b expected 0", $time, wb_en);
			test_err[1]++;
			errors++;
		end
		checks++;
		if (imem_addr !== 32'h0) begin
			$display("ERROR t=%0t imem_addr: got %h expected %h", $time, imem_addr, 32'h0);
			test_err[1]++;
			errors++;
		end
	endtask

	task automatic check_writeback();
		int t;
		if (consumed >= EXP_LEN) begin
			$display("unexpected writeback at t=%0t: register %0d written with %h %s",
				$time, wb_reg, wb_data, "after the last expected write");
			errors++;
		end else begin
			t = exp_test[consumed];
			checks++;
			if (wb_reg !== exp_reg[consumed]) begin
				$display("ERROR t=%0t wb_reg: got %0d expected %0d",
					$time, wb_reg, exp_reg[consumed]);
				test_err[t]++;
				errors++;
			end
			checks++;
			if (wb_data !== exp_val[consumed]) begin
				$display("ERROR t=%0t wb_data: got %h expected %h",
					$time, wb_data, exp_val[consumed]);
				test_err[t]++;
				errors++;
			end
			consumed++;
			// last entry of a test group closes it
			if (consumed == EXP_LEN || exp_test[consumed] != t)
				report_test(t);
		end
	endtask

	// writeback port sampled mid cycle
	always @(negedge clk) begin
		if (arst_n && wb_en)
			check_writeback();
	end

	initial begin
		arst_n   = 1'b0;
		n_prog   = 0;
		n_exp    = 0;
		consumed = 0;
		errors   = 0;
		checks   = 0;
		passed   = 0;
		load_program();
		load_expected();
		@(posedge clk);
		@(negedge clk);
		check_reset_outputs();
		@(posedge clk);
		#1 arst_n = 1'b1;
		@(negedge clk);
		check_reset_outputs();
		report_test(1);
		cycles = 0;
		while (consumed < EXP_LEN && cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (consumed < EXP_LEN) begin
			$display("timeout after %0d cycles with %0d of %0d writebacks seen",
				cycles, consumed, EXP_LEN);
			for (int i = consumed; i < EXP_LEN; i++) begin
				$display("write %0d to register %0d with %h never arrived",
					i, exp_reg[i], exp_val[i]);
				test_err[exp_test[i]]++;
				errors++;
			end
			for (int t = 2; t <= NUM_TESTS; t++) begin
				if (!test_done[t])
					report_test(t);
			end
		end else begin
			// drain so late writes from flushed slots still get caught
			repeat (8) @(posedge clk);
		end
		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			NUM_TESTS, passed, NUM_TESTS - passed, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mips_core.f
+incdir+common
common/mips_pkg.sv
src/fetch_stage.sv
decode/control.sv
decode/reg_file.sv
decode/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/mips_core.sv
testbench/mips_core_tb.sv
